//--- hw/fabric_cfg_defines.svh
`ifndef FABRIC_CFG_DEFINES_SVH
`define FABRIC_CFG_DEFINES_SVH

// ##########################################################
// Bitstream storage
// ##########################################################

// Number of 32-bit words held for the configuration chain
`define CFG_WORDS          3
`define CFG_WORD_BITS      32
`define CFG_MAX_BITS       (`CFG_WORDS * `CFG_WORD_BITS)
// Counter wide enough to hold the full chain length itself
`define CFG_COUNT_BITS     $clog2(`CFG_MAX_BITS + 1)
`define CFG_INDEX_BITS     ((`CFG_WORDS > 1) ? $clog2(`CFG_WORDS) : 1)
`define CFG_BIT_SEL_BITS   $clog2(`CFG_WORD_BITS)
`define CFG_ADDR_BITS      8

// Register bit positions
`define CTRL_START_BIT     0
`define STATUS_BUSY_BIT    0
`define STATUS_DONE_BIT    1

// ##########################################################
// Programming and reset timing, in sys_clk cycles
// ##########################################################
`define PROG_RESET_CYCLES  8
`define PROG_CLK_HALF      2
`define CFG_TIMER_BITS     $clog2(`PROG_RESET_CYCLES + `PROG_CLK_HALF)
`define LOGIC_RESET_CYCLES 20

`endif

//--- hw/fabric_cfg_pkg.sv
`include "fabric_cfg_defines.svh"

package fabric_cfg_pkg;

    // ##########################################################
    // Data word
    // ##########################################################

    // Wishbone data and bitstream storage share one word type
    typedef logic [`CFG_WORD_BITS-1:0] cfg_word_t;

    // ##########################################################
    // Register map
    // ##########################################################

    // Byte addresses on the Wishbone side
    // Bitstream word i sits at BITSTREAM_BASE + 4*i
    typedef enum logic [`CFG_ADDR_BITS-1:0] {
        CTRL           = 8'h00,
        STATUS         = 8'h04,
        BIT_COUNT      = 8'h08,
        BITSTREAM_BASE = 8'h10
    } reg_addr_e;

    // ##########################################################
    // Programming sequencer
    // ##########################################################

    // PRESET holds prog_reset
    // SHIFT_LOW presents data, SHIFT_HIGH clocks it in
    typedef enum logic [1:0] {
        IDLE,
        PRESET,
        SHIFT_LOW,
        SHIFT_HIGH
    } cfg_state_e;

endpackage

//--- hw/clock_divider.sv
`timescale 1ns/1ps

// Divides sys_clk by 2^CLK_DIVIDER_SIZE
// Top counter bit is a 50 % duty logic clock
module clock_divider #(
    parameter int CLK_DIVIDER_SIZE = 3
) (
    input  logic sys_clk,
    input  logic rst_n,
    output logic logic_clk
);

    // Free-running count
    logic [CLK_DIVIDER_SIZE-1:0] count;

    // ##########################################################
    // Counter
    // ##########################################################

    // Wraps naturally at 2^CLK_DIVIDER_SIZE
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // ##########################################################
    // Output
    // ##########################################################

    // MSB toggles every 2^(CLK_DIVIDER_SIZE-1) cycles
    // Straight from a flop, so no glitches on the pad
    assign logic_clk = count[CLK_DIVIDER_SIZE-1];

endmodule

//--- hw/reset_generator.sv
`timescale 1ns/1ps

// Logic reset pulse after rst_n release
// High for ACTIVE_CYCLES sys_clk cycles, then low until next rst_n
module reset_generator #(
    parameter int ACTIVE_CYCLES = 20
) (
    input  logic sys_clk,
    input  logic rst_n,
    output logic logic_reset
);

    // At least one bit, even for a zero length
    localparam int CNT_W = (ACTIVE_CYCLES > 0) ? $clog2(ACTIVE_CYCLES + 1) : 1;

    // Cycles left with logic_reset held high
    logic [CNT_W-1:0] remaining;

    // ##########################################################
    // Down-counter
    // ##########################################################

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            remaining   <= CNT_W'(ACTIVE_CYCLES);
            logic_reset <= 1'b1;
        end else if (remaining != '0) begin
            remaining   <= remaining - 1'b1;
            // Drops on the edge that ends the last active cycle
            logic_reset <= (remaining != CNT_W'(1));
        end else begin
            // Sticky low once expired
            logic_reset <= 1'b0;
        end
    end

endmodule

//--- hw/cfg_wb_regs.sv
`timescale 1ns/1ps
`include "fabric_cfg_defines.svh"

// Wishbone classic slave for the configuration controller
// Holds CTRL, STATUS, BIT_COUNT and the bitstream word memory
module cfg_wb_regs (
    input  logic                            sys_clk,
    input  logic                            rst_n,
    // Wishbone classic slave
    input  logic                            wb_cyc,
    input  logic                            wb_stb,
    input  logic                            wb_we,
    input  logic [`CFG_ADDR_BITS-1:0]       wb_adr,
    input  fabric_cfg_pkg::cfg_word_t       wb_dat_w,
    output fabric_cfg_pkg::cfg_word_t       wb_dat_r,
    output logic                            wb_ack,
    // Configuration manager side
    input  logic [`CFG_INDEX_BITS-1:0]      word_index,
    input  logic                            busy,
    input  logic                            done,
    output logic                            start,
    output logic [`CFG_COUNT_BITS-1:0]      bit_count,
    output fabric_cfg_pkg::cfg_word_t       word_data
);

    localparam int ADDR_W  = `CFG_ADDR_BITS;
    localparam int INDEX_W = `CFG_INDEX_BITS;
    localparam int COUNT_W = `CFG_COUNT_BITS;

    // Bitstream words, payload only
    fabric_cfg_pkg::cfg_word_t mem [`CFG_WORDS];

    logic                  access;
    logic [ADDR_W-1:0]     word_offset;
    logic                  is_word;
    logic [INDEX_W-1:0]    adr_index;
    fabric_cfg_pkg::cfg_word_t rd_data;

    // ##########################################################
    // Address decode
    // ##########################################################

    // New transfer, one per two cycles
    assign access = wb_cyc & wb_stb & ~wb_ack;

    // Word-aligned hit inside the bitstream window
    assign word_offset = wb_adr - fabric_cfg_pkg::BITSTREAM_BASE;
    assign is_word     = (wb_adr >= fabric_cfg_pkg::BITSTREAM_BASE)
                       && (word_offset[1:0] == 2'b00)
                       && (word_offset[ADDR_W-1:2] < `CFG_WORDS);
    assign adr_index   = word_offset[INDEX_W+1:2];

    // ##########################################################
    // Control registers and ack
    // ##########################################################

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack    <= 1'b0;
            start     <= 1'b0;
            bit_count <= '0;
        end else begin
            wb_ack <= access;
            // Start is a single-cycle pulse
            start  <= access && wb_we && !busy
                      && (wb_adr == fabric_cfg_pkg::CTRL)
                      && wb_dat_w[`CTRL_START_BIT];
            if (access && wb_we && !busy && (wb_adr == fabric_cfg_pkg::BIT_COUNT)) begin
                // Clamp to the chain length held in memory
                if (wb_dat_w > `CFG_MAX_BITS) begin
                    bit_count <= COUNT_W'(`CFG_MAX_BITS);
                end else begin
                    bit_count <= wb_dat_w[COUNT_W-1:0];
                end
            end
        end
    end

    // Bitstream writes, frozen while programming
    always_ff @(posedge sys_clk) begin
        if (access && wb_we && !busy && is_word) begin
            mem[adr_index] <= wb_dat_w;
        end
    end

    // ##########################################################
    // Read path
    // ##########################################################

    always_comb begin
        rd_data = '0;
        if (is_word) begin
            rd_data = mem[adr_index];
        end else begin
            case (wb_adr)
                fabric_cfg_pkg::STATUS: begin
                    rd_data[`STATUS_BUSY_BIT] = busy;
                    rd_data[`STATUS_DONE_BIT] = done;
                end
                fabric_cfg_pkg::BIT_COUNT: rd_data[COUNT_W-1:0] = bit_count;
                // CTRL and unmapped space read zero
                default: rd_data = '0;
            endcase
        end
    end

    // Data valid alongside ack
    always_ff @(posedge sys_clk) begin
        if (access && !wb_we) begin
            wb_dat_r <= rd_data;
        end
    end

    // Word for the shifter, zero past the end of memory
    assign word_data = (word_index < `CFG_WORDS) ? mem[word_index] : '0;

endmodule

//--- hw/config_manager.sv
`timescale 1ns/1ps
`include "fabric_cfg_defines.svh"

// Programming sequencer for the fabric configuration chain
// Pulses prog_reset, then shifts bit_count bits into ccff_head MSB-first
module config_manager (
    input  logic                            sys_clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  logic [`CFG_COUNT_BITS-1:0]      bit_count,
    input  fabric_cfg_pkg::cfg_word_t       word_data,
    output logic [`CFG_INDEX_BITS-1:0]      word_index,
    output logic                            prog_clk,
    output logic                            prog_reset,
    output logic                            ccff_head,
    output logic                            busy,
    output logic                            done
);

    localparam int COUNT_W = `CFG_COUNT_BITS;
    localparam int INDEX_W = `CFG_INDEX_BITS;
    localparam int SEL_W   = `CFG_BIT_SEL_BITS;
    localparam int TIMER_W = `CFG_TIMER_BITS;

    fabric_cfg_pkg::cfg_state_e state;

    // Cycles left in the current phase
    logic [TIMER_W-1:0] timer;
    // Index of the next bit to present
    logic [COUNT_W-1:0] bit_ptr;
    logic [SEL_W-1:0]   bit_sel;
    logic               next_bit;

    // ##########################################################
    // Bit selection
    // ##########################################################

    // Word 0 first
    assign word_index = INDEX_W'(bit_ptr / `CFG_WORD_BITS);
    // MSB-first inside a word, word width is a power of two
    assign bit_sel    = ~bit_ptr[SEL_W-1:0];
    assign next_bit   = word_data[bit_sel];

    // ##########################################################
    // Sequencer
    // ##########################################################

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= fabric_cfg_pkg::IDLE;
            timer      <= '0;
            bit_ptr    <= '0;
            prog_clk   <= 1'b0;
            prog_reset <= 1'b0;
            ccff_head  <= 1'b0;
            busy       <= 1'b0;
            done       <= 1'b0;
        end else begin
            case (state)
                fabric_cfg_pkg::IDLE: begin
                    if (start) begin
                        state      <= fabric_cfg_pkg::PRESET;
                        timer      <= TIMER_W'(`PROG_RESET_CYCLES - 1);
                        bit_ptr    <= '0;
                        prog_reset <= 1'b1;
                        busy       <= 1'b1;
                        done       <= 1'b0;
                    end
                end
                fabric_cfg_pkg::PRESET: begin
                    if (timer != '0) begin
                        timer <= timer - 1'b1;
                    end else begin
                        prog_reset <= 1'b0;
                        if (bit_count == '0) begin
                            // Nothing to shift
                            state <= fabric_cfg_pkg::IDLE;
                            busy  <= 1'b0;
                            done  <= 1'b1;
                        end else begin
                            // First bit goes out with prog_clk low
                            state     <= fabric_cfg_pkg::SHIFT_LOW;
                            timer     <= TIMER_W'(`PROG_CLK_HALF - 1);
                            ccff_head <= next_bit;
                            bit_ptr   <= bit_ptr + 1'b1;
                        end
                    end
                end
                fabric_cfg_pkg::SHIFT_LOW: begin
                    if (timer != '0) begin
                        timer <= timer - 1'b1;
                    end else begin
                        state    <= fabric_cfg_pkg::SHIFT_HIGH;
                        timer    <= TIMER_W'(`PROG_CLK_HALF - 1);
                        prog_clk <= 1'b1;
                    end
                end
                fabric_cfg_pkg::SHIFT_HIGH: begin
                    if (timer != '0) begin
                        timer <= timer - 1'b1;
                    end else begin
                        prog_clk <= 1'b0;
                        if (bit_ptr == bit_count) begin
                            // Last edge given
                            state     <= fabric_cfg_pkg::IDLE;
                            ccff_head <= 1'b0;
                            busy      <= 1'b0;
                            done      <= 1'b1;
                        end else begin
                            state     <= fabric_cfg_pkg::SHIFT_LOW;
                            timer     <= TIMER_W'(`PROG_CLK_HALF - 1);
                            ccff_head <= next_bit;
                            bit_ptr   <= bit_ptr + 1'b1;
                        end
                    end
                end
                default: state <= fabric_cfg_pkg::IDLE;
            endcase
        end
    end

endmodule

//--- hw/fabric_test_top.sv
`timescale 1ns/1ps
`include "fabric_cfg_defines.svh"

// Bench-side controller for the fabric test chip
// Logic clock and reset plus host-driven bitstream programming
module fabric_test_top (
    input  logic                            sys_clk,
    input  logic                            rst_n,
    // Host Wishbone classic slave
    input  logic                            wb_cyc,
    input  logic                            wb_stb,
    input  logic                            wb_we,
    input  logic [`CFG_ADDR_BITS-1:0]       wb_adr,
    input  fabric_cfg_pkg::cfg_word_t       wb_dat_w,
    output fabric_cfg_pkg::cfg_word_t       wb_dat_r,
    output logic                            wb_ack,
    // Chip pads
    output logic                            logic_clk,
    output logic                            logic_reset,
    output logic                            prog_clk,
    output logic                            prog_reset,
    output logic                            ccff_head,
    output logic                            configuration_done
);

    // Register block to sequencer
    logic                         start;
    logic [`CFG_COUNT_BITS-1:0]   bit_count;
    fabric_cfg_pkg::cfg_word_t    word_data;
    logic [`CFG_INDEX_BITS-1:0]   word_index;
    logic                         busy;

    // ##########################################################
    // Clocks and resets
    // ##########################################################

    // Small divider keeps simulation short
    clock_divider #(
        .CLK_DIVIDER_SIZE(3)
    ) logic_clk_divider (
        .sys_clk  (sys_clk),
        .rst_n    (rst_n),
        .logic_clk(logic_clk)
    );

    reset_generator #(
        .ACTIVE_CYCLES(`LOGIC_RESET_CYCLES)
    ) logic_reset_generator (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .logic_reset(logic_reset)
    );

    // ##########################################################
    // Configuration
    // ##########################################################

    cfg_wb_regs cfg_regs (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .word_index(word_index),
        .busy      (busy),
        .done      (configuration_done),
        .start     (start),
        .bit_count (bit_count),
        .word_data (word_data)
    );

    config_manager config_mgr (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .start     (start),
        .bit_count (bit_count),
        .word_data (word_data),
        .word_index(word_index),
        .prog_clk  (prog_clk),
        .prog_reset(prog_reset),
        .ccff_head (ccff_head),
        .busy      (busy),
        .done      (configuration_done)
    );

endmodule

//--- tb/tb_fabric_test_top.sv
`timescale 1ns/1ps
`include "fabric_cfg_defines.svh"

module tb_fabric_test_top;

    localparam int NUM_CASES   = 5;
    localparam int MAX_BITS    = `CFG_WORDS * `CFG_WORD_BITS;
    localparam int ACK_TIMEOUT = 10;
    localparam int BIT_CYCLES  = 2 * `PROG_CLK_HALF;

    logic                      sys_clk;
    logic                      rst_n;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    logic [`CFG_ADDR_BITS-1:0] wb_adr;
    fabric_cfg_pkg::cfg_word_t wb_dat_w;
    fabric_cfg_pkg::cfg_word_t wb_dat_r;
    logic                      wb_ack;
    logic                      logic_clk;
    logic                      logic_reset;
    logic                      prog_clk;
    logic                      prog_reset;
    logic                      ccff_head;
    logic                      configuration_done;

    // Stimulus table, one entry per programming run
    int                        case_bits [NUM_CASES];
    fabric_cfg_pkg::cfg_word_t case_words [NUM_CASES][`CFG_WORDS];
    bit                        case_restart [NUM_CASES];

    integer seed = 98;
    int errors = 0;
    int cycle = 0;
    int watchdog_cycles = 0;
    int ack_cycle;
    int done_cycle = -1;
    int release_cycle;
    bit rst_seen = 0;

    // Chain model state
    logic [MAX_BITS-1:0] chain;
    int edges;

    // Monitor state
    int  preset_len = 0;
    int  preset_pulses = 0;
    int  last_toggle = -1;
    int  toggles = 0;
    bit  reset_fell = 0;
    logic prev_logic_clk = 1'b0;
    logic prev_done = 1'b0;

    fabric_test_top DUT (
        .sys_clk           (sys_clk),
        .rst_n             (rst_n),
        .wb_cyc            (wb_cyc),
        .wb_stb            (wb_stb),
        .wb_we             (wb_we),
        .wb_adr            (wb_adr),
        .wb_dat_w          (wb_dat_w),
        .wb_dat_r          (wb_dat_r),
        .wb_ack            (wb_ack),
        .logic_clk         (logic_clk),
        .logic_reset       (logic_reset),
        .prog_clk          (prog_clk),
        .prog_reset        (prog_reset),
        .ccff_head         (ccff_head),
        .configuration_done(configuration_done)
    );

    // 20 ns board clock
    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk) cycle <= cycle + 1;

    // ##########################################################
    // Reporting helpers
    // ##########################################################

    task automatic compare_value(input string name, input logic [MAX_BITS-1:0] expected,
                                 input logic [MAX_BITS-1:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("[ERROR] %0t %s", $time, what);
    endtask

    // ##########################################################
    // Wishbone master
    // ##########################################################

    // Signals held until ack and released 2 ns after the ack edge
    task automatic write_reg(input logic [`CFG_ADDR_BITS-1:0] addr,
                             input fabric_cfg_pkg::cfg_word_t data);
        int waited;
        @(posedge sys_clk);
        #2;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = addr;
        wb_dat_w = data;
        waited   = 0;
        do begin
            @(posedge sys_clk);
            #1;
            waited++;
        end while (!wb_ack && waited < ACK_TIMEOUT);
        assert (wb_ack) else report_failure($sformatf("Write to address %0h got no ack", addr));
        ack_cycle = cycle;
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic read_reg(input logic [`CFG_ADDR_BITS-1:0] addr,
                            output fabric_cfg_pkg::cfg_word_t data);
        int waited;
        @(posedge sys_clk);
        #2;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = addr;
        waited = 0;
        do begin
            @(posedge sys_clk);
            #1;
            waited++;
        end while (!wb_ack && waited < ACK_TIMEOUT);
        assert (wb_ack) else report_failure($sformatf("Read of address %0h got no ack", addr));
        // Read data valid with ack
        data = wb_dat_r;
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic expect_read(input logic [`CFG_ADDR_BITS-1:0] addr,
                               input fabric_cfg_pkg::cfg_word_t expected, input string name);
        fabric_cfg_pkg::cfg_word_t data;
        read_reg(addr, data);
        compare_value($sformatf("wb_dat_r (%s)", name), expected, data);
    endtask

    // ##########################################################
    // Chain model and monitors
    // ##########################################################

    // Fabric chain shifts on rising prog_clk
    always @(posedge prog_clk) begin
        assert (!prog_reset) else report_failure("prog_clk rose while prog_reset was high");
        chain = {chain[MAX_BITS-2:0], ccff_head};
        edges++;
    end

    // Sampled 1 ns after each edge with outputs settled
    always @(posedge sys_clk) begin
        #1;
        if (rst_seen) begin
            // Programming reset pulse width
            if (prog_reset) begin
                preset_len++;
            end else if (preset_len != 0) begin
                compare_value("prog_reset high cycles", `PROG_RESET_CYCLES, preset_len);
                preset_len = 0;
                preset_pulses++;
            end
            // Logic reset release point
            if (!logic_reset && !reset_fell) begin
                reset_fell = 1'b1;
                compare_value("logic_reset high cycles", `LOGIC_RESET_CYCLES,
                              cycle - release_cycle);
            end else if (logic_reset && reset_fell) begin
                report_failure("logic_reset rose again after it was released");
            end
            // Divided clock half period
            if (logic_clk !== prev_logic_clk) begin
                if (last_toggle >= 0) begin
                    compare_value("logic_clk half period", 4, cycle - last_toggle);
                end
                last_toggle = cycle;
                toggles++;
            end
            prev_logic_clk = logic_clk;
            // Done edge and idle levels after it
            if (configuration_done && !prev_done) begin
                done_cycle = cycle;
            end
            prev_done = configuration_done;
            if (configuration_done) begin
                compare_value("prog_clk", 0, prog_clk);
                compare_value("ccff_head", 0, ccff_head);
            end
        end
    end

    // ##########################################################
    // Stimulus table
    // ##########################################################

    task automatic load_table();
        case_bits[0] = 40;
        case_words[0] = '{32'hA5C3_0F96, 32'h1234_5678, 32'hDEAD_BEEF};
        case_restart[0] = 1'b0;
        // Zero count skips shifting
        case_bits[1] = 0;
        case_words[1] = '{32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF};
        case_restart[1] = 1'b0;
        // Full chain of random words
        case_bits[2] = MAX_BITS;
        for (int w = 0; w < `CFG_WORDS; w++) begin
            case_words[2][w] = $random(seed);
        end
        case_restart[2] = 1'b1;
        // Above the chain length so the count saturates
        case_bits[3] = 200;
        case_words[3] = '{32'hFFFF_0000, 32'h0F0F_0F0F, 32'h8000_0001};
        case_restart[3] = 1'b1;
        case_bits[4] = 33;
        case_words[4] = '{32'h0000_0001, 32'h8000_0000, 32'h5555_5555};
        case_restart[4] = 1'b1;
    endtask

    task automatic wait_for_done(input int bits);
        int waited;
        int limit;
        limit  = 1 + `PROG_RESET_CYCLES + bits * BIT_CYCLES + 40;
        waited = 0;
        while (!configuration_done && waited < limit) begin
            @(posedge sys_clk);
            // One step after the edge monitor samples
            #2;
            waited++;
        end
        assert (configuration_done) else report_failure("configuration_done never rose");
    endtask

    task automatic run_case(input int idx);
        int bits;
        int start_cycle;
        logic [MAX_BITS-1:0] stream;
        logic [MAX_BITS-1:0] mask;
        logic [MAX_BITS-1:0] one;
        logic [`CFG_ADDR_BITS-1:0] addr;
        bits = (case_bits[idx] > MAX_BITS) ? MAX_BITS : case_bits[idx];
        one  = 1;
        // Load and read back
        write_reg(fabric_cfg_pkg::BIT_COUNT, case_bits[idx]);
        for (int w = 0; w < `CFG_WORDS; w++) begin
            addr = `CFG_ADDR_BITS'(fabric_cfg_pkg::BITSTREAM_BASE + 4 * w);
            write_reg(addr, case_words[idx][w]);
        end
        expect_read(fabric_cfg_pkg::BIT_COUNT, bits, "BIT_COUNT");
        for (int w = 0; w < `CFG_WORDS; w++) begin
            addr = `CFG_ADDR_BITS'(fabric_cfg_pkg::BITSTREAM_BASE + 4 * w);
            expect_read(addr, case_words[idx][w], $sformatf("bitstream word %0d", w));
        end
        compare_value("prog_clk before start", 0, prog_clk);
        compare_value("ccff_head before start", 0, ccff_head);
        chain = '0;
        edges = 0;
        done_cycle = -1;
        // Start and check busy
        write_reg(fabric_cfg_pkg::CTRL, 32'h1);
        start_cycle = ack_cycle;
        expect_read(fabric_cfg_pkg::STATUS, 32'h1, "STATUS during run");
        if (case_restart[idx]) begin
            // Both ignored while busy
            write_reg(fabric_cfg_pkg::CTRL, 32'h1);
            write_reg(fabric_cfg_pkg::BITSTREAM_BASE, ~case_words[idx][0]);
        end
        wait_for_done(bits);
        compare_value("configuration_done latency",
                      1 + `PROG_RESET_CYCLES + bits * BIT_CYCLES, done_cycle - start_cycle);
        expect_read(fabric_cfg_pkg::STATUS, 32'h2, "STATUS after run");
        // MSB-first with word 0 leading
        stream = '0;
        for (int w = 0; w < `CFG_WORDS; w++) begin
            stream = (stream << `CFG_WORD_BITS) | MAX_BITS'(case_words[idx][w]);
        end
        mask = (one << bits) - 1;
        compare_value("prog_clk rising edges", bits, edges);
        compare_value("chain bits", stream >> (MAX_BITS - bits), chain & mask);
        expect_read(fabric_cfg_pkg::BITSTREAM_BASE, case_words[idx][0], "word 0 after run");
    endtask

    // ##########################################################
    // Main sequence
    // ##########################################################

    initial begin
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        chain    = '0;
        edges    = 0;
        load_table();
        // Budget from the run lengths plus reset
        for (int i = 0; i < NUM_CASES; i++) begin
            watchdog_cycles += 1 + `PROG_RESET_CYCLES + 40
                + ((case_bits[i] > MAX_BITS) ? MAX_BITS : case_bits[i]) * BIT_CYCLES;
        end
        watchdog_cycles += 3;
        repeat (3) @(posedge sys_clk);
        #2;
        rst_n = 1'b1;
        release_cycle = cycle;
        rst_seen = 1'b1;
        // Unmapped, misaligned and CTRL space read zero
        expect_read(8'h00, 32'h0, "CTRL");
        expect_read(8'h0C, 32'h0, "unmapped 0x0C");
        expect_read(8'h12, 32'h0, "misaligned 0x12");
        expect_read(8'h1C, 32'h0, "past last word 0x1C");
        expect_read(8'h80, 32'h0, "unmapped 0x80");
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(i);
        end
        compare_value("prog_reset pulse count", NUM_CASES, preset_pulses);
        assert (reset_fell) else report_failure("logic_reset never fell after reset release");
        assert (toggles > 10) else report_failure("logic_clk did not keep toggling");
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge sys_clk);
        $display("Timeout: tests did not finish within %0d clock cycles", watchdog_cycles);
        $display("Errors: %0d", errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- files.f
+incdir+hw
hw/fabric_cfg_pkg.sv
hw/clock_divider.sv
hw/reset_generator.sv
hw/cfg_wb_regs.sv
hw/config_manager.sv
hw/fabric_test_top.sv
tb/tb_fabric_test_top.sv

//--- Bender.yml
package:
  name: fabric_test

export_include_dirs:
  - hw

sources:
  # RTL in compile order
  - hw/fabric_cfg_pkg.sv
  - hw/clock_divider.sv
  - hw/reset_generator.sv
  - hw/cfg_wb_regs.sv
  - hw/config_manager.sv
  - hw/fabric_test_top.sv

  # Testbench, top module tb_fabric_test_top
  - target: test
    include_dirs:
      - hw
    files:
      - tb/tb_fabric_test_top.sv
